// ==== rtl/tile_pkg.sv ====
// ---------------------------------------------------------------------------
// tile neighbourhood summing package
// shared constants for the 3x3 neighbour walk and the walker FSM states
// ---------------------------------------------------------------------------

`default_nettype none

package tile_pkg;

  // neighbours in one 3x3 bundle
  localparam int unsigned NB_COUNT = 9;

  // width of a neighbour index, 0..NB_COUNT-1
  localparam int unsigned NB_IDX_W = 4;

  // headroom so nine counts never overflow the sum
  localparam int unsigned SUM_EXTRA_W = 4;

  typedef enum logic [0:0] {
    WALK_IDLE,
    WALK_READ
  } walk_state_e;

endpackage

`default_nettype wire

// ==== rtl/tile_coord_clamp_3x3.sv ====
// ---------------------------------------------------------------------------
// 3x3 neighbour coordinate clamp
// expands a centre tile into nine neighbour coordinates, clamped onto the
// grid edge, and holds them in a one-deep valid/ready register slice
// ---------------------------------------------------------------------------

`default_nettype none

module tile_coord_clamp_3x3 #(
  parameter int unsigned TILES_X = 8,
  parameter int unsigned TILES_Y = 6,
  parameter int unsigned TAG_W   = 8
) (
  input  logic                       clk,
  input  logic                       rst,

  // centre request
  input  logic                       center_valid_i,
  output logic                       center_ready_o,
  input  logic [$clog2(TILES_Y)-1:0] center_i_i,
  input  logic [$clog2(TILES_X)-1:0] center_j_i,
  input  logic [TAG_W-1:0]           center_tag_i,

  // neighbour bundle
  output logic                       nb_valid_o,
  input  logic                       nb_ready_i,
  output logic [$clog2(TILES_Y)-1:0] nb_i0_o, nb_i1_o, nb_i2_o,
                                     nb_i3_o, nb_i4_o, nb_i5_o,
                                     nb_i6_o, nb_i7_o, nb_i8_o,
  output logic [$clog2(TILES_X)-1:0] nb_j0_o, nb_j1_o, nb_j2_o,
                                     nb_j3_o, nb_j4_o, nb_j5_o,
                                     nb_j6_o, nb_j7_o, nb_j8_o,
  output logic [TAG_W-1:0]           nb_tag_o
);

  localparam int unsigned I_W = $clog2(TILES_Y);
  localparam int unsigned J_W = $clog2(TILES_X);

  logic                  live;
  logic                  full;
  logic                  in_fire;
  logic                  out_fire;
  logic [8:0][I_W-1:0]   nxt_i;
  logic [8:0][J_W-1:0]   nxt_j;
  logic [8:0][I_W-1:0]   q_i;
  logic [8:0][J_W-1:0]   q_j;
  logic [TAG_W-1:0]      q_tag;

  function automatic int clamp_axis(input int v, input int hi);
    int r;
    r = v;
    if (v < 0) begin
      r = 0;
    end else if (v > hi) begin
      r = hi;
    end
    return r;
  endfunction

  // ---------------------------------------------------------------------------
  // handshake
  // ---------------------------------------------------------------------------
  assign out_fire       = full && nb_ready_i;
  assign center_ready_o = live && (!full || out_fire);
  assign in_fire        = center_valid_i && center_ready_o;
  assign nb_valid_o     = full;

  // ---------------------------------------------------------------------------
  // clamped neighbours, k -> row offset k/3-1, column offset k%3-1
  // ---------------------------------------------------------------------------
  for (genvar k = 0; k < 9; k++) begin : g_nb
    assign nxt_i[k] = I_W'(clamp_axis(int'(center_i_i) + k / 3 - 1, int'(TILES_Y) - 1));
    assign nxt_j[k] = J_W'(clamp_axis(int'(center_j_i) + k % 3 - 1, int'(TILES_X) - 1));
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      live <= 1'b0;
      full <= 1'b0;
    end else begin
      // ready opens on the first clock after reset
      live <= 1'b1;
      if (in_fire) begin
        full <= 1'b1;
      end else if (out_fire) begin
        full <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      q_i   <= nxt_i;
      q_j   <= nxt_j;
      q_tag <= center_tag_i;
    end
  end

  assign nb_i0_o  = q_i[0];
  assign nb_i1_o  = q_i[1];
  assign nb_i2_o  = q_i[2];
  assign nb_i3_o  = q_i[3];
  assign nb_i4_o  = q_i[4];
  assign nb_i5_o  = q_i[5];
  assign nb_i6_o  = q_i[6];
  assign nb_i7_o  = q_i[7];
  assign nb_i8_o  = q_i[8];
  assign nb_j0_o  = q_j[0];
  assign nb_j1_o  = q_j[1];
  assign nb_j2_o  = q_j[2];
  assign nb_j3_o  = q_j[3];
  assign nb_j4_o  = q_j[4];
  assign nb_j5_o  = q_j[5];
  assign nb_j6_o  = q_j[6];
  assign nb_j7_o  = q_j[7];
  assign nb_j8_o  = q_j[8];
  assign nb_tag_o = q_tag;

  // stalled bundle must not change under the walker
  a_nb_hold: assert property (@(posedge clk) disable iff (rst)
    nb_valid_o && !nb_ready_i |=> nb_valid_o && $stable(q_i) && $stable(q_j) && $stable(q_tag));

endmodule

`default_nettype wire

// ==== rtl/nb_walker.sv ====
// ---------------------------------------------------------------------------
// neighbour walker
// takes one 3x3 bundle and issues its nine tile count reads, one per
// cycle, with strobe, last flag and tag delayed to the memory latency
// ---------------------------------------------------------------------------

`default_nettype none

module nb_walker #(
  parameter int unsigned TILES_X = 8,
  parameter int unsigned TILES_Y = 6,
  parameter int unsigned TAG_W   = 8
) (
  input  logic                               clk,
  input  logic                               rst,

  input  logic                               nb_valid_i,
  output logic                               nb_ready_o,
  input  logic [$clog2(TILES_Y)-1:0]         nb_i0_i, nb_i1_i, nb_i2_i,
                                             nb_i3_i, nb_i4_i, nb_i5_i,
                                             nb_i6_i, nb_i7_i, nb_i8_i,
  input  logic [$clog2(TILES_X)-1:0]         nb_j0_i, nb_j1_i, nb_j2_i,
                                             nb_j3_i, nb_j4_i, nb_j5_i,
                                             nb_j6_i, nb_j7_i, nb_j8_i,
  input  logic [TAG_W-1:0]                   nb_tag_i,
  input  logic                               accum_ready_i,

  // memory read port
  output logic                               rd_en_o,
  output logic [$clog2(TILES_X*TILES_Y)-1:0] rd_addr_o,

  // aligned with the returned count
  output logic                               rd_valid_o,
  output logic                               rd_last_o,
  output logic [TAG_W-1:0]                   rd_tag_o
);

  import tile_pkg::*;

  localparam int unsigned I_W = $clog2(TILES_Y);
  localparam int unsigned J_W = $clog2(TILES_X);
  localparam int unsigned A_W = $clog2(TILES_X * TILES_Y);

  walk_state_e         state;
  logic [NB_IDX_W-1:0] idx;
  logic                accept;
  logic                last_rd;
  logic [8:0][I_W-1:0] b_i;
  logic [8:0][J_W-1:0] b_j;
  logic [TAG_W-1:0]    b_tag;

  assign nb_ready_o = (state == WALK_IDLE) && accum_ready_i;
  assign accept     = nb_valid_i && nb_ready_o;
  assign rd_en_o    = (state == WALK_READ);
  assign last_rd    = rd_en_o && (idx == NB_IDX_W'(NB_COUNT - 1));

  // flat address, row major
  assign rd_addr_o = A_W'(int'(b_i[idx]) * TILES_X + int'(b_j[idx]));

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= WALK_IDLE;
      idx        <= '0;
      rd_valid_o <= 1'b0;
      rd_last_o  <= 1'b0;
    end else begin
      rd_valid_o <= rd_en_o;
      rd_last_o  <= last_rd;
      case (state)
        WALK_IDLE: begin
          if (accept) begin
            state <= WALK_READ;
            idx   <= '0;
          end
        end
        WALK_READ: begin
          if (last_rd) begin
            state <= WALK_IDLE;
            idx   <= '0;
          end else begin
            idx <= idx + 1'b1;
          end
        end
        default: state <= WALK_IDLE;
      endcase
    end
  end

  // bundle capture and tag delay
  always_ff @(posedge clk) begin
    if (accept) begin
      b_i   <= {nb_i8_i, nb_i7_i, nb_i6_i, nb_i5_i, nb_i4_i, nb_i3_i, nb_i2_i, nb_i1_i, nb_i0_i};
      b_j   <= {nb_j8_i, nb_j7_i, nb_j6_i, nb_j5_i, nb_j4_i, nb_j3_i, nb_j2_i, nb_j1_i, nb_j0_i};
      b_tag <= nb_tag_i;
    end
    rd_tag_o <= b_tag;
  end

  a_idx_range: assert property (@(posedge clk) disable iff (rst)
    idx <= NB_IDX_W'(NB_COUNT - 1));

endmodule

`default_nettype wire

// ==== rtl/tile_count_mem.sv ====
// ---------------------------------------------------------------------------
// tile count memory
// one count per tile, loaded by row and column, read by flat address
// with a one cycle registered read port
// ---------------------------------------------------------------------------

`default_nettype none

module tile_count_mem #(
  parameter int unsigned TILES_X = 8,
  parameter int unsigned TILES_Y = 6,
  parameter int unsigned COUNT_W = 6
) (
  input  logic                               clk,

  // load port
  input  logic                               wr_en_i,
  input  logic [$clog2(TILES_Y)-1:0]         wr_i_i,
  input  logic [$clog2(TILES_X)-1:0]         wr_j_i,
  input  logic [COUNT_W-1:0]                 wr_count_i,

  // query port
  input  logic                               rd_en_i,
  input  logic [$clog2(TILES_X*TILES_Y)-1:0] rd_addr_i,
  output logic [COUNT_W-1:0]                 rd_data_o
);

  localparam int unsigned DEPTH = TILES_X * TILES_Y;
  localparam int unsigned A_W   = $clog2(DEPTH);

  logic [COUNT_W-1:0] mem [DEPTH];
  logic [A_W-1:0]     wr_addr;

  assign wr_addr = A_W'(int'(wr_i_i) * TILES_X + int'(wr_j_i));

  // no bypass, loads only happen while idle
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_addr] <= wr_count_i;
    end
    if (rd_en_i) begin
      rd_data_o <= mem[rd_addr_i];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/nb_count_accum.sv ====
// ---------------------------------------------------------------------------
// neighbour count accumulator
// adds the nine counts of a bundle and holds the sum and tag on a
// valid/ready result port until it is taken
// ---------------------------------------------------------------------------

`default_nettype none

module nb_count_accum #(
  parameter int unsigned COUNT_W = 6,
  parameter int unsigned TAG_W   = 8
) (
  input  logic                                     clk,
  input  logic                                     rst,

  // counts from memory, strobes from the walker
  input  logic                                     rd_valid_i,
  input  logic                                     rd_last_i,
  input  logic [TAG_W-1:0]                         rd_tag_i,
  input  logic [COUNT_W-1:0]                       rd_data_i,
  output logic                                     accum_ready_o,

  // result
  output logic                                     sum_valid_o,
  input  logic                                     sum_ready_i,
  output logic [COUNT_W+tile_pkg::SUM_EXTRA_W-1:0] sum_o,
  output logic [TAG_W-1:0]                         sum_tag_o
);

  import tile_pkg::*;

  localparam int unsigned SUM_W = COUNT_W + SUM_EXTRA_W;

  logic [SUM_W-1:0]    run_sum;
  logic [SUM_W-1:0]    total;
  logic                held;
  logic [NB_IDX_W-1:0] rd_cnt;

  assign total         = run_sum + SUM_W'(rd_data_i);
  assign accum_ready_o = !held && !(rd_valid_i && rd_last_i);
  assign sum_valid_o   = held;

  always_ff @(posedge clk) begin
    if (rst) begin
      run_sum <= '0;
      rd_cnt  <= '0;
      held    <= 1'b0;
    end else begin
      if (held && sum_ready_i) begin
        held <= 1'b0;
      end
      if (rd_valid_i) begin
        if (rd_last_i) begin
          // restart for the next bundle
          run_sum <= '0;
          rd_cnt  <= '0;
          held    <= 1'b1;
        end else begin
          run_sum <= total;
          rd_cnt  <= rd_cnt + 1'b1;
        end
      end
    end
  end

  // held result
  always_ff @(posedge clk) begin
    if (rd_valid_i && rd_last_i) begin
      sum_o     <= total;
      sum_tag_o <= rd_tag_i;
    end
  end

  // walker must not start a bundle over a held result
  a_no_overrun: assert property (@(posedge clk) disable iff (rst)
    rd_valid_i |-> !held);

  // last flag marks exactly the ninth count
  a_last_pos: assert property (@(posedge clk) disable iff (rst)
    rd_valid_i |-> (rd_last_i == (rd_cnt == NB_IDX_W'(NB_COUNT - 1))));

endmodule

`default_nettype wire

// ==== rtl/tile_nb_sum_top.sv ====
// ---------------------------------------------------------------------------
// tile neighbourhood summing unit
// clamp, walker, count memory and accumulator, returning the sum of the
// nine clamped neighbour counts of a centre tile with its tag
// ---------------------------------------------------------------------------

`default_nettype none

module tile_nb_sum_top #(
  parameter int unsigned TILES_X = 8,
  parameter int unsigned TILES_Y = 6,
  parameter int unsigned TAG_W   = 8,
  parameter int unsigned COUNT_W = 6
) (
  input  logic                                     clk,
  input  logic                                     rst,

  input  logic                                     center_valid_i,
  output logic                                     center_ready_o,
  input  logic [$clog2(TILES_Y)-1:0]               center_i_i,
  input  logic [$clog2(TILES_X)-1:0]               center_j_i,
  input  logic [TAG_W-1:0]                         center_tag_i,

  input  logic                                     wr_en_i,
  input  logic [$clog2(TILES_Y)-1:0]               wr_i_i,
  input  logic [$clog2(TILES_X)-1:0]               wr_j_i,
  input  logic [COUNT_W-1:0]                       wr_count_i,

  output logic                                     sum_valid_o,
  input  logic                                     sum_ready_i,
  output logic [COUNT_W+tile_pkg::SUM_EXTRA_W-1:0] sum_o,
  output logic [TAG_W-1:0]                         sum_tag_o
);

  localparam int unsigned I_W = $clog2(TILES_Y);
  localparam int unsigned J_W = $clog2(TILES_X);
  localparam int unsigned A_W = $clog2(TILES_X * TILES_Y);

  logic               nb_valid;
  logic               nb_ready;
  logic [I_W-1:0]     nb_i0, nb_i1, nb_i2, nb_i3, nb_i4, nb_i5, nb_i6, nb_i7, nb_i8;
  logic [J_W-1:0]     nb_j0, nb_j1, nb_j2, nb_j3, nb_j4, nb_j5, nb_j6, nb_j7, nb_j8;
  logic [TAG_W-1:0]   nb_tag;
  logic               rd_en;
  logic [A_W-1:0]     rd_addr;
  logic               rd_valid;
  logic               rd_last;
  logic [TAG_W-1:0]   rd_tag;
  logic [COUNT_W-1:0] rd_data;
  logic               accum_ready;

  tile_coord_clamp_3x3 #(
    .TILES_X(TILES_X), .TILES_Y(TILES_Y), .TAG_W(TAG_W)
  ) tile_coord_clamp_3x3_inst (
    .clk(clk), .rst(rst),
    .center_valid_i(center_valid_i), .center_ready_o(center_ready_o),
    .center_i_i(center_i_i), .center_j_i(center_j_i), .center_tag_i(center_tag_i),
    .nb_valid_o(nb_valid), .nb_ready_i(nb_ready),
    .nb_i0_o(nb_i0), .nb_i1_o(nb_i1), .nb_i2_o(nb_i2), .nb_i3_o(nb_i3), .nb_i4_o(nb_i4),
    .nb_i5_o(nb_i5), .nb_i6_o(nb_i6), .nb_i7_o(nb_i7), .nb_i8_o(nb_i8),
    .nb_j0_o(nb_j0), .nb_j1_o(nb_j1), .nb_j2_o(nb_j2), .nb_j3_o(nb_j3), .nb_j4_o(nb_j4),
    .nb_j5_o(nb_j5), .nb_j6_o(nb_j6), .nb_j7_o(nb_j7), .nb_j8_o(nb_j8),
    .nb_tag_o(nb_tag)
  );

  nb_walker #(
    .TILES_X(TILES_X), .TILES_Y(TILES_Y), .TAG_W(TAG_W)
  ) nb_walker_inst (
    .clk(clk), .rst(rst),
    .nb_valid_i(nb_valid), .nb_ready_o(nb_ready),
    .nb_i0_i(nb_i0), .nb_i1_i(nb_i1), .nb_i2_i(nb_i2), .nb_i3_i(nb_i3), .nb_i4_i(nb_i4),
    .nb_i5_i(nb_i5), .nb_i6_i(nb_i6), .nb_i7_i(nb_i7), .nb_i8_i(nb_i8),
    .nb_j0_i(nb_j0), .nb_j1_i(nb_j1), .nb_j2_i(nb_j2), .nb_j3_i(nb_j3), .nb_j4_i(nb_j4),
    .nb_j5_i(nb_j5), .nb_j6_i(nb_j6), .nb_j7_i(nb_j7), .nb_j8_i(nb_j8),
    .nb_tag_i(nb_tag), .accum_ready_i(accum_ready),
    .rd_en_o(rd_en), .rd_addr_o(rd_addr),
    .rd_valid_o(rd_valid), .rd_last_o(rd_last), .rd_tag_o(rd_tag)
  );

  tile_count_mem #(
    .TILES_X(TILES_X), .TILES_Y(TILES_Y), .COUNT_W(COUNT_W)
  ) tile_count_mem_inst (
    .clk(clk),
    .wr_en_i(wr_en_i), .wr_i_i(wr_i_i), .wr_j_i(wr_j_i), .wr_count_i(wr_count_i),
    .rd_en_i(rd_en), .rd_addr_i(rd_addr), .rd_data_o(rd_data)
  );

  nb_count_accum #(
    .COUNT_W(COUNT_W), .TAG_W(TAG_W)
  ) nb_count_accum_inst (
    .clk(clk), .rst(rst),
    .rd_valid_i(rd_valid), .rd_last_i(rd_last), .rd_tag_i(rd_tag), .rd_data_i(rd_data),
    .accum_ready_o(accum_ready),
    .sum_valid_o(sum_valid_o), .sum_ready_i(sum_ready_i),
    .sum_o(sum_o), .sum_tag_o(sum_tag_o)
  );

endmodule

`default_nettype wire

// ==== sim/tb_tile_nb_sum.sv ====
// ---------------------------------------------------------------------------
// tile neighbourhood summing unit testbench
// loads tile counts, sends centre requests and checks every returned sum
// and tag against a shadow copy of the counts, with and without
// back-pressure on the result port
// ---------------------------------------------------------------------------

`default_nettype none

module tb_tile_nb_sum;

  timeunit 1ns;
  timeprecision 1ps;

  import tile_pkg::*;

  localparam int TILES_X     = 8;
  localparam int TILES_Y     = 6;
  localparam int TAG_W       = 8;
  localparam int COUNT_W     = 6;
  localparam int I_W         = $clog2(TILES_Y);
  localparam int J_W         = $clog2(TILES_X);
  localparam int SUM_W       = COUNT_W + SUM_EXTRA_W;
  localparam int N_EDGE      = 8;
  localparam int N_INTERIOR  = 20;
  localparam int N_BP        = 30;
  localparam int N_RELOAD    = 20;
  localparam int N_STREAM    = 50;
  localparam int N_REQ       = N_EDGE + N_INTERIOR + N_BP + N_RELOAD + N_STREAM;
  localparam int LOAD_CYCLES = 3 * TILES_X * TILES_Y + 100;

  logic             clk;
  logic             rst;
  logic             center_valid_i;
  logic             center_ready_o;
  logic [I_W-1:0]   center_i_i;
  logic [J_W-1:0]   center_j_i;
  logic [TAG_W-1:0] center_tag_i;
  logic             wr_en_i;
  logic [I_W-1:0]   wr_i_i;
  logic [J_W-1:0]   wr_j_i;
  logic [COUNT_W-1:0] wr_count_i;
  logic             sum_valid_o;
  logic             sum_ready_i;
  logic [SUM_W-1:0] sum_o;
  logic [TAG_W-1:0] sum_tag_o;

  integer seed;
  int     shadow [TILES_X*TILES_Y];
  int     exp_i_q[$];
  int     exp_j_q[$];
  int     exp_tag_q[$];
  int     tag_next;
  int     results_seen;
  bit     bp_mode;
  string  test_name;

  tile_nb_sum_top #(
    .TILES_X(TILES_X), .TILES_Y(TILES_Y), .TAG_W(TAG_W), .COUNT_W(COUNT_W)
  ) tile_nb_sum_top_inst (
    .clk(clk), .rst(rst),
    .center_valid_i(center_valid_i), .center_ready_o(center_ready_o),
    .center_i_i(center_i_i), .center_j_i(center_j_i), .center_tag_i(center_tag_i),
    .wr_en_i(wr_en_i), .wr_i_i(wr_i_i), .wr_j_i(wr_j_i), .wr_count_i(wr_count_i),
    .sum_valid_o(sum_valid_o), .sum_ready_i(sum_ready_i),
    .sum_o(sum_o), .sum_tag_o(sum_tag_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ---------------------------------------------------------------------------
  // reference model and helpers
  // ---------------------------------------------------------------------------

  // sum of the nine neighbours with each axis clamped onto the grid edge
  function automatic int ref_sum(input int ci, input int cj);
    int total;
    int r;
    int c;
    total = 0;
    for (int k = 0; k < NB_COUNT; k++) begin
      r = ci + k / 3 - 1;
      c = cj + k % 3 - 1;
      r = (r < 0) ? 0 : ((r > TILES_Y - 1) ? TILES_Y - 1 : r);
      c = (c < 0) ? 0 : ((c > TILES_X - 1) ? TILES_X - 1 : c);
      total += shadow[r * TILES_X + c];
    end
    return total;
  endfunction

  task automatic abort_run();
    $display(">>> FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string what, input int expected, input int actual);
    if (expected !== actual) begin
      $display("error [%s] %s: expected %0d, actual %0d", test_name, what, expected, actual);
      abort_run();
    end
  endtask

  task automatic write_count(input int r, input int c, input int v);
    wr_en_i    = 1'b1;
    wr_i_i     = I_W'(r);
    wr_j_i     = J_W'(c);
    wr_count_i = COUNT_W'(v);
    shadow[r * TILES_X + c] = v;
    @(negedge clk);
    wr_en_i = 1'b0;
  endtask

  // distinct counts so repeated edge tiles show up in the sum
  task automatic load_pattern();
    for (int r = 0; r < TILES_Y; r++) begin
      for (int c = 0; c < TILES_X; c++) begin
        write_count(r, c, ((r * TILES_X + c) * 5 + 3) % (1 << COUNT_W));
      end
    end
  endtask

  task automatic load_random(input int n_tiles);
    int r;
    int c;
    for (int k = 0; k < n_tiles; k++) begin
      r = {$random(seed)} % TILES_Y;
      c = {$random(seed)} % TILES_X;
      write_count(r, c, {$random(seed)} % (1 << COUNT_W));
    end
  endtask

  // request stays valid until the slice takes it
  task automatic send_request(input int ci, input int cj);
    center_valid_i = 1'b1;
    center_i_i     = I_W'(ci);
    center_j_i     = J_W'(cj);
    center_tag_i   = TAG_W'(tag_next);
    while (center_ready_o !== 1'b1) @(negedge clk);
    exp_i_q.push_back(ci);
    exp_j_q.push_back(cj);
    exp_tag_q.push_back(tag_next % (1 << TAG_W));
    tag_next++;
    @(negedge clk);
    center_valid_i = 1'b0;
  endtask

  task automatic send_random_batch(input int n, input bit interior);
    int ri[$];
    int rj[$];
    for (int k = 0; k < n; k++) begin
      if (interior) begin
        ri.push_back(1 + {$random(seed)} % (TILES_Y - 2));
        rj.push_back(1 + {$random(seed)} % (TILES_X - 2));
      end else begin
        ri.push_back({$random(seed)} % TILES_Y);
        rj.push_back({$random(seed)} % TILES_X);
      end
    end
    foreach (ri[k]) send_request(ri[k], rj[k]);
  endtask

  task automatic wait_drain();
    while (exp_tag_q.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk);
  endtask

  // ---------------------------------------------------------------------------
  // result ready drive and compare
  // ---------------------------------------------------------------------------
  initial begin : compare_results
    int ci;
    int cj;
    int tg;
    forever begin
      @(negedge clk);
      if (bp_mode) begin
        sum_ready_i = $random(seed) & 1;
      end else begin
        sum_ready_i = !rst;
      end
      if (!rst && sum_valid_o && sum_ready_i) begin
        if (exp_tag_q.size() == 0) begin
          $display("a result appeared with no request outstanding, tag %0d", sum_tag_o);
          abort_run();
        end
        ci = exp_i_q.pop_front();
        cj = exp_j_q.pop_front();
        tg = exp_tag_q.pop_front();
        check_value("result tag", tg, int'(sum_tag_o));
        check_value($sformatf("sum at (%0d,%0d)", ci, cj), ref_sum(ci, cj), int'(sum_o));
        results_seen++;
      end
    end
  end

  initial begin : watchdog
    repeat (N_REQ * 40 + LOAD_CYCLES) @(posedge clk);
    $display("timeout in %s, only %0d of %0d results came back", test_name, results_seen,
             N_REQ);
    abort_run();
  end

  // ---------------------------------------------------------------------------
  // test sequence
  // ---------------------------------------------------------------------------
  initial begin : main_seq
    seed           = 32'h1991;
    rst            = 1'b1;
    center_valid_i = 1'b0;
    center_i_i     = '0;
    center_j_i     = '0;
    center_tag_i   = '0;
    wr_en_i        = 1'b0;
    wr_i_i         = '0;
    wr_j_i         = '0;
    wr_count_i     = '0;
    sum_ready_i    = 1'b0;
    // start near the top so tags wrap through zero and every tag bit toggles
    tag_next       = 200;
    results_seen   = 0;
    bp_mode        = 1'b0;
    test_name      = "reset";

    repeat (8) begin
      @(negedge clk);
      check_value("center_ready_o in reset", 0, int'(center_ready_o));
      check_value("sum_valid_o in reset", 0, int'(sum_valid_o));
    end
    rst = 1'b0;
    check_value("center_ready_o at release", 0, int'(center_ready_o));
    @(negedge clk);
    check_value("center_ready_o after release", 1, int'(center_ready_o));
    repeat (20) @(negedge clk);
    check_value("sum_valid_o while idle", 0, int'(sum_valid_o));

    test_name = "corner and edge";
    load_pattern();
    send_request(0, 0);
    send_request(0, TILES_X - 1);
    send_request(TILES_Y - 1, 0);
    send_request(TILES_Y - 1, TILES_X - 1);
    send_request(0, TILES_X / 2);
    send_request(TILES_Y - 1, TILES_X / 2);
    send_request(TILES_Y / 2, 0);
    send_request(TILES_Y / 2, TILES_X - 1);
    wait_drain();

    test_name = "interior";
    load_random(TILES_X * TILES_Y);
    send_random_batch(N_INTERIOR, 1'b1);
    wait_drain();

    test_name = "back-pressure";
    bp_mode = 1'b1;
    send_random_batch(N_BP, 1'b0);
    wait_drain();
    bp_mode = 1'b0;

    // partial rewrite while nothing is in flight
    test_name = "reload";
    load_random(16);
    send_random_batch(N_RELOAD, 1'b0);
    wait_drain();

    test_name = "stream";
    send_random_batch(N_STREAM, 1'b0);
    wait_drain();

    if (results_seen == N_REQ && exp_tag_q.size() == 0 && sum_valid_o === 1'b0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("expected %0d results but received %0d", N_REQ, results_seen);
      $display(">>> FAIL");
      $fatal(1, "result count mismatch");
    end
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/tile_pkg.sv
rtl/tile_coord_clamp_3x3.sv
rtl/nb_walker.sv
rtl/tile_count_mem.sv
rtl/nb_count_accum.sv
rtl/tile_nb_sum_top.sv
sim/tb_tile_nb_sum.sv

// ==== Bender.yml ====
package:
  name: tile_nb_sum

sources:
  - files:
      - rtl/tile_pkg.sv
      - rtl/tile_coord_clamp_3x3.sv
      - rtl/nb_walker.sv
      - rtl/tile_count_mem.sv
      - rtl/nb_count_accum.sv
      - rtl/tile_nb_sum_top.sv
  - target: simulation
    files:
      - sim/tb_tile_nb_sum.sv
